// ==== hw/bpPkg.sv ====
package bpPkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int ADDR_BITS  = 32;                 // pc and target width
    localparam int INDEX_BITS = 5;                  // set index, pc[6:2]
    localparam int TAG_BITS   = 25;                 // tag, pc[31:7]
    localparam int NUM_SETS   = 1 << INDEX_BITS;
    localparam int NUM_WAYS   = 4;
    localparam int WAY_BITS   = 2;                  // victim pointer width

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,                            // not a branch, never stored
        BR_COND = 2'b01,
        BR_JUMP = 2'b10
    } brType_t;

    // local history on top, then one counter per history pattern
    typedef struct packed {
        logic [1:0] hist;                           // newest outcome in bit 0
        logic [1:0] ctr3;
        logic [1:0] ctr2;
        logic [1:0] ctr1;
        logic [1:0] ctr0;
    } bpLog_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
        logic [ADDR_BITS-1:0] target;
        brType_t              brType;
    } buildReq_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
        logic                 taken;                // resolved direction
    } updateReq_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
    } fetchReq_t;

    typedef struct packed {
        logic                 hit;
        logic [ADDR_BITS-1:0] target;
        brType_t              brType;
        bpLog_t               log;
    } wayLookup_t;

    typedef struct packed {
        logic                 valid;
        logic                 hit;
        logic                 taken;
        logic [ADDR_BITS-1:0] target;
        brType_t              brType;
    } predResp_t;

endpackage

// ==== hw/historyLog.sv ====
module historyLog import bpPkg::*; (
    input  brType_t brType,
    input  logic    backward,                       // target below pc
    input  logic    taken,
    input  bpLog_t  oldLog,
    output bpLog_t  initLog,
    output bpLog_t  nextLog
);

    logic [1:0] selCtr;                             // counter picked by hist
    logic [1:0] newCtr;

    ////////////////////////////////////////////////////////////
    // log for a freshly built entry
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (brType)
            BR_JUMP: initLog = '{hist: 2'b11, ctr3: 2'b11, ctr2: 2'b11,
                                 ctr1: 2'b11, ctr0: 2'b11};
            BR_COND: begin
                if (backward) begin                 // loops lean taken
                    initLog = '{hist: 2'b11, ctr3: 2'b10, ctr2: 2'b10,
                                ctr1: 2'b10, ctr0: 2'b01};
                end else begin
                    initLog = '{hist: 2'b00, ctr3: 2'b10, ctr2: 2'b01,
                                ctr1: 2'b01, ctr0: 2'b01};
                end
            end
            default: initLog = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // training on a resolved outcome
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (oldLog.hist)
            2'd0:    selCtr = oldLog.ctr0;
            2'd1:    selCtr = oldLog.ctr1;
            2'd2:    selCtr = oldLog.ctr2;
            default: selCtr = oldLog.ctr3;
        endcase

        if (taken) begin
            newCtr = (selCtr == 2'b11) ? 2'b11 : selCtr + 2'd1;  // saturate high
        end else begin
            newCtr = (selCtr == 2'b00) ? 2'b00 : selCtr - 2'd1;  // saturate low
        end

        nextLog = oldLog;
        nextLog.hist = {oldLog.hist[0], taken};     // shift in newest outcome
        case (oldLog.hist)
            2'd0:    nextLog.ctr0 = newCtr;
            2'd1:    nextLog.ctr1 = newCtr;
            2'd2:    nextLog.ctr2 = newCtr;
            default: nextLog.ctr3 = newCtr;
        endcase
    end

endmodule

// ==== hw/predWay.sv ====
module predWay import bpPkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  buildReq_t  build,
    input  logic       wayWrite,                    // this way takes the build
    input  updateReq_t update,
    input  fetchReq_t  fetch,

    output logic       buildHit,                    // build pc already stored here
    output logic       buildFree,                   // build set empty in this way
    output wayLookup_t lookup
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    logic [NUM_SETS-1:0]  validArr;
    logic [TAG_BITS-1:0]  tagArr    [NUM_SETS];
    logic [ADDR_BITS-1:0] targetArr [NUM_SETS];
    brType_t              typeArr   [NUM_SETS];
    bpLog_t               logArr    [NUM_SETS];

    logic [INDEX_BITS-1:0] bIdx;
    logic [INDEX_BITS-1:0] uIdx;
    logic [INDEX_BITS-1:0] fIdx;
    logic [TAG_BITS-1:0]   bTag;
    logic [TAG_BITS-1:0]   uTag;
    logic [TAG_BITS-1:0]   fTag;

    logic   updHit;
    logic   backward;
    bpLog_t initLog;
    bpLog_t nextLog;

    assign bIdx = build.pc[INDEX_BITS+1:2];
    assign uIdx = update.pc[INDEX_BITS+1:2];
    assign fIdx = fetch.pc[INDEX_BITS+1:2];

    assign bTag = build.pc[ADDR_BITS-1:INDEX_BITS+2];
    assign uTag = update.pc[ADDR_BITS-1:INDEX_BITS+2];
    assign fTag = fetch.pc[ADDR_BITS-1:INDEX_BITS+2];

    ////////////////////////////////////////////////////////////
    // three read ports
    ////////////////////////////////////////////////////////////

    // build port, feeds the allocator
    assign buildHit  = validArr[bIdx] && (tagArr[bIdx] == bTag);
    assign buildFree = !validArr[bIdx];

    // update port
    assign updHit = update.valid && validArr[uIdx] && (tagArr[uIdx] == uTag);

    // fetch port, raw entry, merged in hitSelect
    assign lookup.hit    = validArr[fIdx] && (tagArr[fIdx] == fTag);
    assign lookup.target = targetArr[fIdx];
    assign lookup.brType = typeArr[fIdx];
    assign lookup.log    = logArr[fIdx];

    assign backward = build.target < build.pc;

    historyLog uLog (
        .brType   (build.brType),
        .backward (backward),
        .taken    (update.taken),
        .oldLog   (logArr[uIdx]),
        .initLog  (initLog),
        .nextLog  (nextLog)
    );

    ////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            validArr <= '0;
        end else if (wayWrite) begin
            validArr[bIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updHit) begin
            logArr[uIdx] <= nextLog;                // train on outcome
        end
        if (wayWrite) begin                         // a build wins on the same entry
            tagArr[bIdx]    <= bTag;
            targetArr[bIdx] <= build.target;
            typeArr[bIdx]   <= build.brType;
            logArr[bIdx]    <= initLog;
        end
    end

    // only real branches are ever stored
    noHitOnNone: assert property (
        @(posedge clk) disable iff (!rstn)
        lookup.hit |-> (lookup.brType != BR_NONE)
    );

endmodule

// ==== hw/wayAlloc.sv ====
module wayAlloc import bpPkg::*; (
    input  logic                clk,
    input  logic                rstn,

    input  buildReq_t           build,
    input  logic [NUM_WAYS-1:0] buildHit,       // per way duplicate flag
    input  logic [NUM_WAYS-1:0] buildFree,      // per way empty flag

    output logic [NUM_WAYS-1:0] wayWrite        // one-hot, zero when idle
);

    logic [WAY_BITS-1:0] victim;                // round robin pointer
    logic                doWrite;
    logic                setFull;
    logic [NUM_WAYS-1:0] lowFree;
    logic [NUM_WAYS-1:0] victimSel;

    ////////////////////////////////////////////////////////////
    // way choice
    ////////////////////////////////////////////////////////////

    // drop non-branches and anything already stored
    assign doWrite = build.valid && (build.brType != BR_NONE) && !(|buildHit);
    assign setFull = !(|buildFree);

    // isolate the lowest set bit
    assign lowFree   = buildFree & (~buildFree + 1'b1);
    assign victimSel = {{(NUM_WAYS-1){1'b0}}, 1'b1} << victim;

    always_comb begin
        if (!doWrite) begin
            wayWrite = '0;
        end else if (setFull) begin
            wayWrite = victimSel;               // evict
        end else begin
            wayWrite = lowFree;
        end
    end

    ////////////////////////////////////////////////////////////
    // victim pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            victim <= '0;
        end else if (doWrite && setFull) begin
            victim <= victim + 1'b1;            // wraps mod NUM_WAYS
        end
    end

    wayWriteOneHot: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(wayWrite)
    );

endmodule

// ==== hw/hitSelect.sv ====
module hitSelect import bpPkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  fetchReq_t  fetch,
    input  wayLookup_t lookup [NUM_WAYS],

    output predResp_t  pred
);

    logic [NUM_WAYS-1:0]  hitVec;
    logic                 anyHit;
    bpLog_t               selLog;
    logic [ADDR_BITS-1:0] selTarget;
    brType_t              selType;
    logic                 selTaken;

    logic                 respValid;
    logic                 respHit;
    logic                 respTaken;
    logic [ADDR_BITS-1:0] respTarget;
    brType_t              respType;

    // merge ways, zeros on a miss
    always_comb begin
        anyHit    = 1'b0;
        selLog    = '0;
        selTarget = '0;
        selType   = BR_NONE;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hitVec[w] = lookup[w].hit;
            if (lookup[w].hit && !anyHit) begin
                anyHit    = 1'b1;
                selLog    = lookup[w].log;
                selTarget = lookup[w].target;
                selType   = lookup[w].brType;
            end
        end
    end

    // direction is the msb of the counter the history points at
    always_comb begin
        case (selLog.hist)
            2'd0:    selTaken = selLog.ctr0[1];
            2'd1:    selTaken = selLog.ctr1[1];
            2'd2:    selTaken = selLog.ctr2[1];
            default: selTaken = selLog.ctr3[1];
        endcase
    end

    ////////////////////////////////////////////////////////////
    // response register, one cycle latency
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            respValid <= 1'b0;
            respHit   <= 1'b0;
        end else begin
            respValid <= fetch.valid;
            respHit   <= fetch.valid && anyHit;
        end
    end

    always_ff @(posedge clk) begin
        respTaken  <= selTaken;
        respTarget <= selTarget;
        respType   <= selType;
    end

    assign pred = '{valid: respValid, hit: respHit, taken: respTaken,
                    target: respTarget, brType: respType};

    // duplicate check at build keeps tags unique within a set
    singleWayHit: assert property (
        @(posedge clk) disable iff (!rstn)
        fetch.valid |-> $onehot0(hitVec)
    );

endmodule

// ==== hw/branchPredictor.sv ====
module branchPredictor import bpPkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  buildReq_t  build,                   // from decode
    input  updateReq_t update,                  // from execute
    input  fetchReq_t  fetch,                   // from fetch

    output predResp_t  pred
);

    logic [NUM_WAYS-1:0] buildHit;
    logic [NUM_WAYS-1:0] buildFree;
    logic [NUM_WAYS-1:0] wayWrite;
    wayLookup_t          lookup [NUM_WAYS];

    ////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////

    wayAlloc uAlloc (
        .clk       (clk),
        .rstn      (rstn),
        .build     (build),
        .buildHit  (buildHit),
        .buildFree (buildFree),
        .wayWrite  (wayWrite)
    );

    ////////////////////////////////////////////////////////////
    // ways
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gWay
        predWay uWay (
            .clk       (clk),
            .rstn      (rstn),
            .build     (build),
            .wayWrite  (wayWrite[w]),
            .update    (update),
            .fetch     (fetch),
            .buildHit  (buildHit[w]),
            .buildFree (buildFree[w]),
            .lookup    (lookup[w])
        );
    end

    ////////////////////////////////////////////////////////////
    // prediction
    ////////////////////////////////////////////////////////////

    hitSelect uSelect (
        .clk    (clk),
        .rstn   (rstn),
        .fetch  (fetch),
        .lookup (lookup),
        .pred   (pred)
    );

endmodule

// ==== dv/bpTests.svh ====
`ifndef BP_TESTS_SVH
`define BP_TESTS_SVH

// empty predictor answers every fetch with a miss
task automatic resetState();
    checkBool(1'b0, pred.valid, "pred.valid after reset");
    checkBool(1'b0, pred.hit, "pred.hit after reset");
    predictPc(32'h0000_1040);
    checkBool(1'b0, pred.hit, "hit on empty predictor");
    predictPc(32'hdead_beec);
    checkBool(1'b1, pred.valid, "valid one cycle after fetch");
endtask

task automatic buildAndPredict();
    buildBranch(32'h0000_1040, 32'h0000_1000, BR_COND);     // backward, set 16
    buildBranch(32'h0000_2044, 32'h0000_2100, BR_COND);     // forward, set 17
    buildBranch(32'h0000_3048, 32'h0000_4000, BR_JUMP);
    buildBranch(32'h0000_504c, 32'h0000_5000, BR_NONE);     // must be dropped
    predictPc(32'h0000_1040);
    checkBool(1'b1, pred.hit, "backward branch hit");
    checkBool(1'b1, pred.taken, "backward branch taken");
    checkBool(1'b1, pred.target == 32'h0000_1000, "backward branch target");
    predictPc(32'h0000_2044);
    checkBool(1'b1, pred.hit, "forward branch hit");
    checkBool(1'b0, pred.taken, "forward branch not taken");
    predictPc(32'h0000_3048);
    checkBool(1'b1, pred.taken, "jump taken");
    predictPc(32'h0000_504c);
    checkBool(1'b0, pred.hit, "non-branch not stored");
endtask

task automatic counterTraining();
    logic [4:0] outcome;
    logic [4:0] expTaken;
    outcome  = 5'b01011;                                    // T T N T N from bit 0
    expTaken = 5'b11010;                                    // worked out by hand
    buildBranch(32'h0000_6014, 32'h0000_6200, BR_COND);
    for (int i = 0; i < 5; i++) begin
        resolveBranch(32'h0000_6014, outcome[i]);
        predictPc(32'h0000_6014);
        checkBool(expTaken[i], pred.taken, $sformatf("taken after update %0d", i));
    end
    resolveBranch(32'h0000_7014, 1'b1);                     // same set, never built
    predictPc(32'h0000_7014);
    checkBool(1'b0, pred.hit, "unbuilt pc hit");
    predictPc(32'h0000_6014);
    checkBool(1'b1, pred.taken, "log moved by a missed update");
endtask

task automatic wayReplacement();
    logic [31:0] pcs [5];
    for (int i = 0; i < 5; i++) begin
        pcs[i] = 32'h0001_0050 + 32'h0001_0000 * i;         // set 20, distinct tags
    end
    buildBranch(pcs[0], 32'h0000_0100, BR_JUMP);
    buildBranch(pcs[0], 32'h0000_0200, BR_JUMP);            // duplicate, ignored
    for (int i = 1; i < 4; i++) begin
        buildBranch(pcs[i], 32'h0000_0100, BR_JUMP);
    end
    for (int i = 0; i < 4; i++) begin
        predictPc(pcs[i]);
        checkBool(1'b1, pred.hit, $sformatf("tag %0d present in full set", i));
    end
    buildBranch(pcs[4], 32'h0000_0300, BR_JUMP);            // evicts way 0
    predictPc(pcs[0]);
    checkBool(1'b0, pred.hit, "first tag survived eviction");
    predictPc(pcs[4]);
    checkBool(1'b1, pred.hit, "fifth tag missing");
endtask

// random traffic over sets 8 to 15 with eight tags
function automatic logic [31:0] randomPc(logic [2:0] set, logic [2:0] tag);
    return {22'd0, tag, 2'b01, set, 2'b00};
endfunction

task automatic randomTraffic();
    buildReq_t   b;
    updateReq_t  u;
    fetchReq_t   f;
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  uSet;
    for (int n = 0; n < RAND_CYCLES; n++) begin
        r  = $random(seed);
        r2 = $random(seed);
        uSet = (r[5:3] == r[2:0]) ? r[2:0] + 3'd1 : r[5:3];  // keep off the build set
        b.valid  = r[6];
        b.pc     = randomPc(r[2:0], r[9:7]);
        b.target = {21'd0, r2[10:0]};
        b.brType = brType_t'((r[11:10] == 2'b11) ? 2'b01 : r[11:10]);
        u.valid  = r[12];
        u.pc     = randomPc(uSet, r[15:13]);
        u.taken  = r[16];
        f.valid  = r[17] | r[18];
        f.pc     = randomPc(r[21:19], r[24:22]);
        issueCycle(b, u, f, $sformatf("random cycle %0d", n));
    end
endtask

`endif

// ==== dv/tbBranchPredictor.sv ====
module tbBranchPredictor import bpPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_DELAY  = 1;                 // ns after the rising edge
    localparam int RAND_CYCLES = 300;
    localparam int MAX_CYCLES  = 2000;              // ~40 directed plus 300 random, wide margin

    logic       clk = 1'b0;
    logic       rstn;
    buildReq_t  build;
    updateReq_t update;
    fetchReq_t  fetch;
    predResp_t  pred;

    int     cycles = 0;
    int     predErrors = 0;
    int     flagErrors = 0;
    integer seed = 32'heefd;

    // reference model, hist in bits 9:8, counter n in bits 2n+1:2n
    logic                 mValid  [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0]  mTag    [NUM_SETS][NUM_WAYS];
    logic [ADDR_BITS-1:0] mTarget [NUM_SETS][NUM_WAYS];
    brType_t              mType   [NUM_SETS][NUM_WAYS];
    logic [9:0]           mLog    [NUM_SETS][NUM_WAYS];
    int                   mVictim = 0;

    always #5 clk = ~clk;

    branchPredictor i_dut (
        .clk    (clk),
        .rstn   (rstn),
        .build  (build),
        .update (update),
        .fetch  (fetch),
        .pred   (pred)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int findWay(logic [31:0] pc);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mValid[pc[6:2]][w] && mTag[pc[6:2]][w] == pc[31:7]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic predResp_t expectedPred(fetchReq_t f);
        predResp_t  r;
        int         w;
        logic [9:0] lg;
        r = '0;
        r.valid = f.valid;
        w = findWay(f.pc);
        if (f.valid && w >= 0) begin
            lg       = mLog[f.pc[6:2]][w];
            r.hit    = 1'b1;
            r.taken  = lg[2 * lg[9:8] + 1];         // msb of the counter hist selects
            r.target = mTarget[f.pc[6:2]][w];
            r.brType = mType[f.pc[6:2]][w];
        end
        return r;
    endfunction

    function automatic void storeEntry(buildReq_t b);
        int s;
        int w;
        s = b.pc[6:2];
        w = -1;
        if (!b.valid || b.brType == BR_NONE || findWay(b.pc) >= 0) begin
            return;
        end
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!mValid[s][i]) begin
                w = i;                              // ends on the lowest free way
            end
        end
        if (w < 0) begin
            w = mVictim;
            mVictim = (mVictim + 1) % NUM_WAYS;
        end
        mValid[s][w]  = 1'b1;
        mTag[s][w]    = b.pc[31:7];
        mTarget[s][w] = b.target;
        mType[s][w]   = b.brType;
        if (b.brType == BR_JUMP) begin
            mLog[s][w] = 10'b11_11_11_11_11;
        end else if (b.target < b.pc) begin
            mLog[s][w] = 10'b11_10_10_10_01;
        end else begin
            mLog[s][w] = 10'b00_10_01_01_01;
        end
    endfunction

    function automatic void trainEntry(updateReq_t u);
        int         w;
        int         p;
        logic [9:0] lg;
        logic [1:0] c;
        w = findWay(u.pc);
        if (!u.valid || w < 0) begin
            return;
        end
        lg = mLog[u.pc[6:2]][w];
        p  = lg[9:8];
        c  = lg[2 * p +: 2];
        if (u.taken && c != 2'b11) begin
            c = c + 2'd1;
        end else if (!u.taken && c != 2'b00) begin
            c = c - 2'd1;
        end
        lg[2 * p +: 2] = c;
        lg[9:8] = {lg[8], u.taken};
        mLog[u.pc[6:2]][w] = lg;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and drivers
    ////////////////////////////////////////////////////////////

    function automatic string predText(predResp_t p);
        return $sformatf("v%0b h%0b t%0b tgt %h type %0d", p.valid, p.hit, p.taken,
                         p.target, p.brType);
    endfunction

    task automatic checkPred(predResp_t exp, predResp_t act, string what);
        logic bad;
        bad = (act.valid !== exp.valid) || (act.hit !== exp.hit);
        if (exp.valid) begin
            bad = bad || (act.taken !== exp.taken) || (act.target !== exp.target)
                      || (act.brType !== exp.brType);
        end
        if (bad) begin
            predErrors++;
            $display("Mismatch at %0t: %s, expected %s, got %s", $time, what,
                     predText(exp), predText(act));
        end
    endtask

    task automatic checkBool(logic exp, logic act, string what);
        if (act !== exp) begin
            flagErrors++;
            $display("Mismatch at %0t: %s, expected %0b, got %0b", $time, what, exp, act);
        end
    endtask

    // one clock of requests, pred compared right after the edge
    task automatic issueCycle(buildReq_t b, updateReq_t u, fetchReq_t f, string what);
        predResp_t exp;
        exp    = expectedPred(f);                   // old contents
        build  = b;
        update = u;
        fetch  = f;
        @(posedge clk);
        #STIM_DELAY;
        build  = '0;
        update = '0;
        fetch  = '0;
        trainEntry(u);
        storeEntry(b);
        checkPred(exp, pred, what);
    endtask

    task automatic buildBranch(logic [31:0] pc, logic [31:0] target, brType_t t);
        buildReq_t b;
        b = '{valid: 1'b1, pc: pc, target: target, brType: t};
        issueCycle(b, '0, '0, $sformatf("build %h", pc));
    endtask

    task automatic resolveBranch(logic [31:0] pc, logic taken);
        updateReq_t u;
        u = '{valid: 1'b1, pc: pc, taken: taken};
        issueCycle('0, u, '0, $sformatf("update %h", pc));
    endtask

    task automatic predictPc(logic [31:0] pc);
        fetchReq_t f;
        f = '{valid: 1'b1, pc: pc};
        issueCycle('0, '0, f, $sformatf("predict %h", pc));
    endtask

    `include "bpTests.svh"

    initial begin
        build  = '0;
        update = '0;
        fetch  = '0;
        rstn   = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                mValid[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #STIM_DELAY;
        rstn = 1'b1;

        resetState();
        buildAndPredict();
        counterTraining();
        wayReplacement();
        randomTraffic();

        $display("errors: %0d prediction mismatches, %0d flag mismatches",
                 predErrors, flagErrors);
        if (predErrors + flagErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+dv
hw/bpPkg.sv
hw/historyLog.sv
hw/predWay.sv
hw/wayAlloc.sv
hw/hitSelect.sv
hw/branchPredictor.sv
dv/tbBranchPredictor.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= tbBranchPredictor
RTL_TOP   ?= branchPredictor
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
